// ==== logic/arcade_rom_consts.svh ====
// Arcade ROM memory map
`ifndef ARCADE_ROM_CONSTS_SVH
`define ARCADE_ROM_CONSTS_SVH

// Region offsets in the download stream, in bytes
`define SCR_START   25'h01_0000
`define OBJ_START   25'h01_8000
`define PROM_START  25'h02_0000     // PROM data runs to the end of the stream

// Standard pixel enable ratio, n over m
`define CEN_N_STD   10'd1
`define CEN_M_STD   10'd4

// Alternate ratio for the slightly faster pixel clock
`define CEN_N_ALT   10'd32
`define CEN_M_ALT   10'd125

`endif

// ==== logic/arcade_rom_pkg.sv ====
// Arcade ROM shared types
`default_nettype none

package arcade_rom_pkg;

    typedef logic [24:0] ioctl_addr_t;  // Loader byte address
    typedef logic [21:0] sdram_addr_t;  // 16-bit word address
    typedef logic [15:0] sdram_word_t;
    typedef logic [12:0] gfx_addr_t;    // In 32-bit units
    typedef logic [31:0] gfx_data_t;
    typedef logic [15:0] main_addr_t;   // CPU byte address

    // Read fetcher states
    typedef enum logic [2:0] {
        st_idle,
        st_request,
        st_release,
        st_beat0,
        st_beat1
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== logic/pxl_cen_gen.sv ====
// Fractional pixel enable generator
`timescale 1ns/1ps
`default_nettype none
`include "arcade_rom_consts.svh"

module pxl_cen_gen (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        alt_rate,
    output logic [3:0] cen
);

logic [ 9:0] n, m;
logic [10:0] acc, acc_sum;
logic [ 2:0] cnt;      // Counts cen[0] pulses
logic        alt_q;

assign n       = alt_rate ? `CEN_N_ALT : `CEN_N_STD;
assign m       = alt_rate ? `CEN_M_ALT : `CEN_M_STD;
assign acc_sum = acc + {1'b0, n};

always_ff @(posedge clk) begin
    if (!rst_n) begin
        acc   <= '0;
        cnt   <= '0;
        alt_q <= 1'b0;
        cen   <= '0;
    end else begin
        alt_q <= alt_rate;
        cen   <= '0;
        if (alt_q != alt_rate) begin
            // A leftover from the old ratio could exceed the new m
            acc <= '0;
        end else if (acc_sum >= {1'b0, m}) begin
            acc    <= acc_sum - {1'b0, m};
            cnt    <= cnt + 3'd1;
            cen[0] <= 1'b1;
            cen[1] <= cnt[0];       // Every 2nd
            cen[2] <= &cnt[1:0];    // Every 4th
            cen[3] <= &cnt;         // Every 8th
        end else begin
            acc <= acc_sum;
        end
    end
end

endmodule

`default_nettype wire

// ==== logic/rom_dwnld.sv ====
// ROM download to SDRAM writes
`timescale 1ns/1ps
`default_nettype none
`include "arcade_rom_consts.svh"

module rom_dwnld import arcade_rom_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              downloading,
    input  wire ioctl_addr_t ioctl_addr,
    input  wire [7:0]        ioctl_dout,
    input  wire              ioctl_wr,
    input  wire              sdram_ack,
    output sdram_addr_t      prog_addr,
    output logic [7:0]       prog_data,
    output logic [1:0]       prog_mask,     // Active low
    output logic             prog_we,
    output logic             prom_we
);

localparam ioctl_addr_t scr_start  = `SCR_START;
localparam ioctl_addr_t obj_start  = `OBJ_START;
localparam ioctl_addr_t prom_start = `PROM_START;

sdram_addr_t pre_addr, swz_addr;
ioctl_addr_t prom_offset;
logic        in_scr, in_obj, in_prom;
logic        wr_en;

assign pre_addr    = ioctl_addr[22:1];
assign prom_offset = ioctl_addr - prom_start;
assign in_prom     = ioctl_addr >= prom_start;
assign in_scr      = ioctl_addr >= scr_start && ioctl_addr < obj_start;
assign in_obj      = ioctl_addr >= obj_start && !in_prom;
assign wr_en       = downloading && ioctl_wr;

// Tile and sprite bit planes are reordered so a 32-bit read gets a full row
always_comb begin
    swz_addr = pre_addr;
    if (in_scr) begin
        swz_addr[0]   = ~pre_addr[3];
        swz_addr[3:1] = pre_addr[2:0];
    end
    if (in_obj) begin
        swz_addr[0]   = ~pre_addr[3];
        swz_addr[1]   = ~pre_addr[4];
        swz_addr[5:2] = {pre_addr[5], pre_addr[2:0]};
    end
    if (in_prom) begin
        swz_addr = prom_offset[21:0];   // Byte offset into the PROMs
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        prog_we <= 1'b0;
        prom_we <= 1'b0;
    end else begin
        prom_we <= wr_en && in_prom;    // Single cycle strobe
        if (wr_en && !in_prom) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;            // Write taken by the SDRAM
        end
    end
end

always_ff @(posedge clk) begin
    if (wr_en) begin
        prog_addr <= swz_addr;
        prog_data <= ioctl_dout;
        prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
    end
end

endmodule

`default_nettype wire

// ==== logic/rom_slots.sv ====
// Cached ROM slots on one SDRAM port
`timescale 1ns/1ps
`default_nettype none
`include "arcade_rom_consts.svh"

module rom_slots import arcade_rom_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              downloading,
    // Scroll tiles
    input  wire              scr_cs,
    input  wire gfx_addr_t   scr_addr,
    output gfx_data_t        scr_data,
    output logic             scr_ok,
    // Sprites
    input  wire              obj_cs,
    input  wire gfx_addr_t   obj_addr,
    output gfx_data_t        obj_data,
    output logic             obj_ok,
    // CPU program
    input  wire              main_cs,
    input  wire main_addr_t  main_addr,
    output logic [7:0]       main_data,
    output logic             main_ok,
    // SDRAM read port
    output logic             sdram_req,
    input  wire              sdram_ack,
    output sdram_addr_t      sdram_addr,
    input  wire sdram_word_t data_read,
    input  wire              data_rdy
);

localparam sdram_addr_t scr_offset = sdram_addr_t'(`SCR_START >> 1);
localparam sdram_addr_t obj_offset = sdram_addr_t'(`OBJ_START >> 1);

fetch_state_t state;
sdram_addr_t  slot_addr  [3];   // Word address each consumer wants
sdram_addr_t  cache_addr [3];
gfx_data_t    cache_data [3];
logic [2:0]   valid, hit, miss;
logic [1:0]   pick, sel;
sdram_word_t  beat_lo;

assign slot_addr[0] = scr_offset + sdram_addr_t'({scr_addr, 1'b0});
assign slot_addr[1] = obj_offset + sdram_addr_t'({obj_addr, 1'b0});
assign slot_addr[2] = sdram_addr_t'(main_addr[15:1]);

always_comb begin
    for (int i = 0; i < 3; i++) begin
        hit[i] = valid[i] && cache_addr[i] == slot_addr[i];
    end
end

assign miss = {main_cs, obj_cs, scr_cs} & ~hit;

// Fixed priority, scroll first
always_comb begin
    if (miss[0]) begin
        pick = 2'd0;
    end else if (miss[1]) begin
        pick = 2'd1;
    end else begin
        pick = 2'd2;
    end
end

assign scr_ok    = hit[0];
assign obj_ok    = hit[1];
assign main_ok   = hit[2];
assign scr_data  = cache_data[0];
assign obj_data  = cache_data[1];
assign main_data = main_addr[0] ? cache_data[2][15:8] : cache_data[2][7:0];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state     <= st_idle;
        sdram_req <= 1'b0;
        sel       <= 2'd0;
        valid     <= '0;
    end else begin
        case (state)
            st_idle: begin
                // Previous ack must be gone before a new request
                if (!downloading && !sdram_ack && |miss) begin
                    sel       <= pick;
                    sdram_req <= 1'b1;
                    state     <= st_request;
                end
            end
            st_request: begin
                if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= st_release;
                end
            end
            st_release: begin
                if (data_rdy) begin
                    state <= st_beat1;  // First word came early
                end else if (!sdram_ack) begin
                    state <= st_beat0;
                end
            end
            st_beat0: begin
                if (data_rdy) begin
                    state <= st_beat1;
                end
            end
            st_beat1: begin
                if (data_rdy) begin
                    valid[sel] <= 1'b1;
                    state      <= st_idle;
                end
            end
            default: state <= st_idle;
        endcase
        if (downloading) begin
            valid <= '0;    // ROM contents are changing
        end
    end
end

always_ff @(posedge clk) begin
    if (state == st_idle) begin
        sdram_addr <= slot_addr[pick];  // Frozen once the request is up
    end
    if (data_rdy && (state == st_release || state == st_beat0)) begin
        beat_lo <= data_read;
    end
    if (data_rdy && state == st_beat1) begin
        cache_addr[sel] <= sdram_addr;
        cache_data[sel] <= {data_read, beat_lo};
    end
end

endmodule

`default_nettype wire

// ==== logic/arcade_rom_top.sv ====
// Arcade ROM memory side
`timescale 1ns/1ps
`default_nettype none

module arcade_rom_top import arcade_rom_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    // Pixel enables
    input  wire              alt_rate,
    output logic [3:0]       cen,
    // ROM download
    input  wire              downloading,
    input  wire ioctl_addr_t ioctl_addr,
    input  wire [7:0]        ioctl_dout,
    input  wire              ioctl_wr,
    output sdram_addr_t      prog_addr,
    output logic [7:0]       prog_data,
    output logic [1:0]       prog_mask,
    output logic             prog_we,
    output logic             prom_we,
    // ROM slots
    input  wire              scr_cs,
    input  wire gfx_addr_t   scr_addr,
    output gfx_data_t        scr_data,
    output logic             scr_ok,
    input  wire              obj_cs,
    input  wire gfx_addr_t   obj_addr,
    output gfx_data_t        obj_data,
    output logic             obj_ok,
    input  wire              main_cs,
    input  wire main_addr_t  main_addr,
    output logic [7:0]       main_data,
    output logic             main_ok,
    // SDRAM, one ack shared by writes and reads
    output logic             sdram_req,
    input  wire              sdram_ack,
    output sdram_addr_t      sdram_addr,
    input  wire sdram_word_t data_read,
    input  wire              data_rdy
);

pxl_cen_gen u_cen (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .alt_rate   ( alt_rate  ),
    .cen        ( cen       )
);

rom_dwnld u_dwnld (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .downloading ( downloading ),
    .ioctl_addr  ( ioctl_addr  ),
    .ioctl_dout  ( ioctl_dout  ),
    .ioctl_wr    ( ioctl_wr    ),
    .sdram_ack   ( sdram_ack   ),
    .prog_addr   ( prog_addr   ),
    .prog_data   ( prog_data   ),
    .prog_mask   ( prog_mask   ),
    .prog_we     ( prog_we     ),
    .prom_we     ( prom_we     )
);

rom_slots u_slots (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .downloading ( downloading ),
    .scr_cs      ( scr_cs      ),
    .scr_addr    ( scr_addr    ),
    .scr_data    ( scr_data    ),
    .scr_ok      ( scr_ok      ),
    .obj_cs      ( obj_cs      ),
    .obj_addr    ( obj_addr    ),
    .obj_data    ( obj_data    ),
    .obj_ok      ( obj_ok      ),
    .main_cs     ( main_cs     ),
    .main_addr   ( main_addr   ),
    .main_data   ( main_data   ),
    .main_ok     ( main_ok     ),
    .sdram_req   ( sdram_req   ),
    .sdram_ack   ( sdram_ack   ),
    .sdram_addr  ( sdram_addr  ),
    .data_read   ( data_read   ),
    .data_rdy    ( data_rdy    )
);

endmodule

`default_nettype wire

// ==== verification/arcade_rom_assertions.sv ====
// SDRAM handshake and enable checks
`timescale 1ns/1ps
`default_nettype none

module arcade_rom_assertions (
    input wire       clk,
    input wire       rst_n,
    input wire       sdram_req,
    input wire       sdram_ack,
    input wire [3:0] cen
);

// Request stays up until the SDRAM takes it
req_held: assert property (@(posedge clk) disable iff (!rst_n)
    sdram_req && !sdram_ack |=> sdram_req)
    else $error("sdram_req dropped before sdram_ack");

no_req_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(sdram_req) |-> !$past(sdram_ack))
    else $error("sdram_req raised while sdram_ack was still high");

cen1_on_cen0: assert property (@(posedge clk) disable iff (!rst_n)
    cen[1] |-> cen[0])
    else $error("cen[1] pulsed without cen[0]");

endmodule

bind rom_slots arcade_rom_assertions i_slots_chk (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .sdram_req ( sdram_req ),
    .sdram_ack ( sdram_ack ),
    .cen       ( 4'd0      )
);

bind pxl_cen_gen arcade_rom_assertions i_cen_chk (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .sdram_req ( 1'b0      ),
    .sdram_ack ( 1'b0      ),
    .cen       ( cen       )
);

`default_nettype wire

// ==== verification/arcade_rom_tb.sv ====
// Arcade ROM testbench
`timescale 1ns/1ps
`default_nettype none
`include "arcade_rom_consts.svh"

module arcade_rom_tb import arcade_rom_pkg::*;;

logic        clk, rst_n, alt_rate, downloading, ioctl_wr;
logic [3:0]  cen;
ioctl_addr_t ioctl_addr;
logic [7:0]  ioctl_dout, prog_data, main_data;
sdram_addr_t prog_addr, sdram_addr;
logic [1:0]  prog_mask;
logic        prog_we, prom_we, scr_cs, obj_cs, main_cs, scr_ok, obj_ok, main_ok;
gfx_addr_t   scr_addr, obj_addr;
gfx_data_t   scr_data, obj_data;
main_addr_t  main_addr;
logic        sdram_req, sdram_ack, data_rdy;
sdram_word_t data_read;

logic [7:0]  rec_kind [$];      // Parsed pattern records
logic [31:0] rec_f1 [$], rec_f2 [$], rec_f3 [$];
int          n_cen = 0;
bit          loaded = 0;
sdram_word_t mem [sdram_addr_t];

arcade_rom_top i_dut (.*);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

task automatic next_cycle;
    @(posedge clk);
    #1;     // Drive and sample just after the edge
endtask

task automatic fail_run;
    $display("sim failed");
    $fatal(1);
endtask

task automatic report_error(string msg);
    $display("Error: %s", msg);
    fail_run();
endtask

task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    fail_run();
endtask

function automatic sdram_word_t mem_read(sdram_addr_t a);
    if (mem.exists(a)) return mem[a];
    return a[15:0] ^ {10'd0, a[21:16]};    // Fill for words never written
endfunction

function automatic bit slot_ok(int s);
    case (s)
        0:       return scr_ok;
        1:       return obj_ok;
        default: return main_ok;
    endcase
endfunction

function automatic bit is_close(int a, int b, int tol);
    return (a > b ? a - b : b - a) <= tol;
endfunction

// SDRAM model, acks after 1 to 4 cycles
initial begin : sdram_model
    sdram_addr_t raddr;
    sdram_word_t w;
    void'($urandom(99));
    sdram_ack = 1'b0;
    data_rdy  = 1'b0;
    data_read = '0;
    forever begin
        next_cycle();
        if (prog_we) begin
            repeat ($urandom_range(4, 1)) next_cycle();
            w = mem_read(prog_addr);
            if (!prog_mask[0]) w[7:0] = prog_data;     // Mask is active low
            if (!prog_mask[1]) w[15:8] = prog_data;
            mem[prog_addr] = w;
            sdram_ack = 1'b1;
            next_cycle();
            sdram_ack = 1'b0;
        end else if (sdram_req) begin
            raddr = sdram_addr;
            repeat ($urandom_range(4, 1)) next_cycle();
            sdram_ack = 1'b1;
            while (sdram_req) next_cycle();
            sdram_ack = 1'b0;
            repeat ($urandom_range(4, 1)) next_cycle();
            data_rdy  = 1'b1;
            data_read = mem_read(raddr);
            next_cycle();
            data_read = mem_read(raddr + 22'd1);
            next_cycle();
            data_rdy  = 1'b0;
        end
    end
end

initial begin : watchdog
    int limit;
    wait (loaded);
    limit = rec_kind.size() * 200 + n_cen * 1000;
    repeat (limit) @(posedge clk);
    report_error("Timeout, the run did not finish in time");
end

task automatic set_download(bit on);
    if (downloading != on) begin
        downloading = on;
        next_cycle();
    end
endtask

task automatic download_byte(logic [31:0] a, logic [31:0] d, logic [31:0] exp_addr);
    bit is_prom;
    is_prom    = a[24:0] >= `PROM_START;
    ioctl_addr = a[24:0];
    ioctl_dout = d[7:0];
    ioctl_wr   = 1'b1;
    next_cycle();
    ioctl_wr   = 1'b0;
    assert (prog_addr == exp_addr[21:0])
        else report_mismatch("prog_addr", 32'(prog_addr), exp_addr);
    assert (prog_data == d[7:0]) else report_mismatch("prog_data", 32'(prog_data), d);
    if (is_prom) begin
        assert (prom_we && !prog_we) else report_error("PROM byte gave no lone prom_we");
        next_cycle();
        assert (!prom_we && !prog_we) else report_error("prom_we lasted over one cycle");
    end else begin
        assert (prog_we && !prom_we) else report_error("prog_we late after ioctl_wr");
        assert (prog_mask == {~a[0], a[0]})     // Odd bytes go high
            else report_mismatch("prog_mask", 32'(prog_mask), 32'({~a[0], a[0]}));
        while (prog_we) next_cycle();
    end
endtask

task automatic read_slot(int slot, logic [31:0] a, logic [31:0] exp);
    int waited;
    waited    = 0;
    scr_addr  = a[12:0];
    obj_addr  = a[12:0];
    main_addr = a[15:0];
    scr_cs    = slot == 0;
    obj_cs    = slot == 1;
    main_cs   = slot == 2;
    next_cycle();
    while (!slot_ok(slot) && waited < 200) begin
        next_cycle();
        waited++;
    end
    assert (slot_ok(slot)) else report_error("Slot never raised ok");
    case (slot)
        0:       assert (scr_data == exp) else report_mismatch("scr_data", scr_data, exp);
        1:       assert (obj_data == exp) else report_mismatch("obj_data", obj_data, exp);
        default: assert (main_data == exp[7:0])
                     else report_mismatch("main_data", 32'(main_data), exp);
    endcase
    {scr_cs, obj_cs, main_cs} = 3'b000;
endtask

// All three slots miss at once
task automatic check_priority(logic [31:0] a0, logic [31:0] a1, logic [31:0] a2);
    int          order [$];
    bit [2:0]    seen;
    int          waited;
    logic [31:0] order_code;
    seen      = '0;
    waited    = 0;
    scr_addr  = a0[12:0];
    obj_addr  = a1[12:0];
    main_addr = a2[15:0];
    {scr_cs, obj_cs, main_cs} = 3'b111;
    while (seen != 3'b111 && waited < 300) begin
        next_cycle();
        waited++;
        for (int s = 0; s < 3; s++) begin
            if (slot_ok(s) && !seen[s]) begin
                seen[s] = 1'b1;
                order.push_back(s);
            end
        end
    end
    assert (seen == 3'b111) else report_error("Not every slot got served");
    order_code = {20'd0, 4'(order[0]), 4'(order[1]), 4'(order[2])};
    assert (order_code == 32'h012) else report_mismatch("ok_order", order_code, 32'h012);
    {scr_cs, obj_cs, main_cs} = 3'b000;
endtask

task automatic measure_cen(bit alt, int exp);
    int c0, c1, c2, c3;
    alt_rate = alt;
    repeat (16) next_cycle();  // Let the accumulator settle
    {c0, c1, c2, c3} = '0;
    repeat (1000) begin
        next_cycle();
        c0 += int'(cen[0]);
        c1 += int'(cen[1]);
        c2 += int'(cen[2]);
        c3 += int'(cen[3]);
    end
    assert (is_close(c0, exp, 1)) else report_mismatch("cen0_count", c0, exp);
    assert (is_close(2 * c1, c0, 2)) else report_mismatch("cen1_count", c1, c0 / 2);
    assert (is_close(4 * c2, c0, 4)) else report_mismatch("cen2_count", c2, c0 / 4);
    assert (is_close(8 * c3, c0, 8)) else report_mismatch("cen3_count", c3, c0 / 8);
endtask

initial begin : main_flow
    int                 fd, code;
    logic [7:0]         kind;
    logic [31:0]        f1, f2, f3;
    logic [8*128-1:0]   skip;
    rst_n = 1'b0;
    {alt_rate, downloading, ioctl_wr, scr_cs, obj_cs, main_cs} = '0;
    ioctl_addr = '0;
    ioctl_dout = '0;
    scr_addr   = '0;
    obj_addr   = '0;
    main_addr  = '0;
    fd = $fopen("verification/arcade_rom_patterns.txt", "r");
    if (fd == 0) report_error("Cannot open the pattern file");
    while ($fscanf(fd, " %c", kind) == 1) begin
        if (kind == "#") begin
            code = $fgets(skip, fd);    // Rest of a comment line
        end else begin
            code = $fscanf(fd, "%h %h %h", f1, f2, f3);
            if (code != 3) report_error("Malformed pattern record");
            rec_kind.push_back(kind);
            rec_f1.push_back(f1);
            rec_f2.push_back(f2);
            rec_f3.push_back(f3);
            if (kind == "C") n_cen++;
        end
    end
    $fclose(fd);
    loaded = 1'b1;
    repeat (3) next_cycle();
    assert (!sdram_req && !prog_we && !prom_we && cen == '0 && !scr_ok && !obj_ok && !main_ok)
        else report_error("Outputs not low during reset");
    rst_n = 1'b1;
    next_cycle();
    for (int i = 0; i < rec_kind.size(); i++) begin
        set_download(rec_kind[i] == "D");
        case (rec_kind[i])
            "D":     download_byte(rec_f1[i], rec_f2[i], rec_f3[i]);
            "R":     read_slot(int'(rec_f1[i]), rec_f2[i], rec_f3[i]);
            "Q":     check_priority(rec_f1[i], rec_f2[i], rec_f3[i]);
            "C":     measure_cen(rec_f1[i][0], int'(rec_f2[i]));
            default: report_error("Unknown record kind in the pattern file");
        endcase
    end
    $display("sim passed");
    $finish;
end

endmodule

`default_nettype wire

// ==== verification/arcade_rom_patterns.txt ====
# kind f1 f2 f3, all hex. D byte_addr data exp_word_addr, R slot addr exp_data (0 scr 1 obj 2 main)
# Q scr_addr obj_addr main_addr (order check), C alt_rate exp_cen0_count_per_1000 unused
D 10000 A1 8001
D 10001 B2 8001
D 10010 C3 8000
D 10011 D4 8000
D 1001F 9C 800E
D 18020 11 C001
D 18021 22 C001
D 18030 33 C000
D 18031 44 C000
D 1807E 5D C03C
D 00004 5A 2
D 00005 6B 2
D 20003 7E 3
D 2010A 3F 10A
R 0 0 B2A1D4C3
R 1 0 22114433
R 2 4 5A
R 2 5 6B
Q 1 1 6
C 0 FA 0
C 1 100 0

// ==== arcade_rom.f ====
+incdir+logic
logic/arcade_rom_pkg.sv
logic/pxl_cen_gen.sv
logic/rom_dwnld.sv
logic/rom_slots.sv
logic/arcade_rom_top.sv
verification/arcade_rom_assertions.sv
verification/arcade_rom_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = arcade_rom_tb
FILELIST  = arcade_rom.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf $(OBJ_DIR)
